//--- cpu_subsys_glue.f
+incdir+.
subsys_pkg.sv
ahbl_rdata_aligner.sv
subsys_ctrl.sv
cpu_subsys_glue.sv
tb_cpu_subsys_glue.sv

//--- Bender.yml
package:
  name: cpu_subsys_glue

export_include_dirs:
  - .

sources:
  - files:
      - subsys_pkg.sv
      - ahbl_rdata_aligner.sv
      - subsys_ctrl.sv
      - cpu_subsys_glue.sv
  - target: test
    files:
      - tb_cpu_subsys_glue.sv

//--- tb_cpu_subsys_glue.sv
//--------------------------------------------------------------------------
// Testbench for the core glue: three read aligners and the control block.
// Inputs change on the falling cpu_clk edge and are checked on the next
// falling edge, so every check sees values held across one rising edge.
// The expected capture per port is kept here from the AHB-Lite
// acceptance rule. Stimulus comes from an LCG with a fixed seed.
// The run is far too short to reach the wrap of the 64-bit counter.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "subsys_defs.svh"

module tb_cpu_subsys_glue;

  localparam int NPORT       = 3;
  localparam int RST_CYCLES  = 10;
  localparam int RAND_CYCLES = 600;
  localparam int WAIT_LIMIT  = 50;

  logic                         cpu_clk;
  logic                         pg_reset_b;
  logic                         hartreset_n;
  logic                         ndmreset_n;
  logic [1:0]                   nmi_wake_int_lower;

  // port order is sys, ibus, dbus
  subsys_pkg::ahb_addr_phase_t  ap [NPORT];
  subsys_pkg::ahb_data_phase_t  dp [NPORT];
  subsys_pkg::ahb_rd_aligned_t  sys_rd;
  subsys_pkg::ahb_rd_aligned_t  ibus_rd;
  subsys_pkg::ahb_rd_aligned_t  dbus_rd;
  subsys_pkg::ahb_rd_aligned_t  rd_arr [NPORT];

  logic                         cpu_rst_b;
  logic                         sys_rst;
  logic                         cpu_nmi;
  logic                         cpu_wakeup;
  logic [`SYS_CNT_W-1:0]        sys_cnt;

  // expected capture per port
  logic [2:0]                   exp_size [NPORT];
  logic [1:0]                   exp_ofs [NPORT];
  logic [`SYS_CNT_W-1:0]        cnt_prev;
  logic [31:0]                  lcg_state;
  string                        port_name [NPORT];

  cpu_subsys_glue u_dut (
    .cpu_clk            (cpu_clk),
    .pg_reset_b         (pg_reset_b),
    .hartreset_n        (hartreset_n),
    .ndmreset_n         (ndmreset_n),
    .nmi_wake_int_lower (nmi_wake_int_lower),
    .sys_addr_phase     (ap[0]),
    .ibus_addr_phase    (ap[1]),
    .dbus_addr_phase    (ap[2]),
    .sys_data_phase     (dp[0]),
    .ibus_data_phase    (dp[1]),
    .dbus_data_phase    (dp[2]),
    .sys_rd             (sys_rd),
    .ibus_rd            (ibus_rd),
    .dbus_rd            (dbus_rd),
    .cpu_rst_b          (cpu_rst_b),
    .sys_rst            (sys_rst),
    .cpu_nmi            (cpu_nmi),
    .cpu_wakeup         (cpu_wakeup),
    .sys_cnt            (sys_cnt)
  );

  // 4 ns period
  always #2 cpu_clk = ~cpu_clk;

  // outputs indexed like the inputs
  always_comb begin
    rd_arr[0] = sys_rd;
    rd_arr[1] = ibus_rd;
    rd_arr[2] = dbus_rd;
  end

  // common exit for any failed check
  task automatic stop_run(input string why);
    $display("Test failed");
    $display("%s", why);
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    stop_run($sformatf("mismatch at %0d ns: %s got 0x%0h expected 0x%0h",
                       $time, name, got, exp));
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp)
      else report_mismatch(name, got, exp);
  endtask

  // hready and err forwarding sampled on every rising edge
  assert property (@(posedge cpu_clk)
                   {sys_rd.hready, sys_rd.err} == {dp[0].hready, dp[0].hresp[0]})
    else report_mismatch("sys_rd.{hready,err}", {sys_rd.hready, sys_rd.err},
                         {dp[0].hready, dp[0].hresp[0]});
  assert property (@(posedge cpu_clk)
                   {ibus_rd.hready, ibus_rd.err} == {dp[1].hready, dp[1].hresp[0]})
    else report_mismatch("ibus_rd.{hready,err}", {ibus_rd.hready, ibus_rd.err},
                         {dp[1].hready, dp[1].hresp[0]});
  assert property (@(posedge cpu_clk)
                   {dbus_rd.hready, dbus_rd.err} == {dp[2].hready, dp[2].hresp[0]})
    else report_mismatch("dbus_rd.{hready,err}", {dbus_rd.hready, dbus_rd.err},
                         {dp[2].hready, dp[2].hresp[0]});

  // numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte lanes the core keeps for a given size and offset
  function automatic logic [31:0] lane_mask(input logic [2:0] size,
                                            input logic [1:0] ofs);
    logic [31:0] mask;
    mask = 32'h0;
    case (size)
      3'd0: begin
        mask = 32'h0000_00ff << (8 * ofs);
      end
      3'd1: begin
        // halfword only on even halves
        if (ofs == 2'd0) begin
          mask = 32'h0000_ffff;
        end else if (ofs == 2'd2) begin
          mask = 32'hffff_0000;
        end
      end
      3'd2: begin
        if (ofs == 2'd0) begin
          mask = 32'hffff_ffff;
        end
      end
      default: begin
        mask = 32'h0;
      end
    endcase
    return mask;
  endfunction

  // one rising edge then a check of everything on the falling edge
  task automatic step_and_check();
    logic [`SYS_CNT_W-1:0] cnt_exp;
    @(negedge cpu_clk);
    for (int p = 0; p < NPORT; p++) begin
      // reset wins over nonseq reads accepted with hready
      if (!pg_reset_b) begin
        exp_size[p] = 3'd2;
        exp_ofs[p]  = 2'd0;
      end else if (dp[p].hready && !ap[p].hwrite
                   && ap[p].htrans == subsys_pkg::HTRANS_NONSEQ) begin
        exp_size[p] = ap[p].hsize;
        exp_ofs[p]  = ap[p].haddr[1:0];
      end
      check_val({port_name[p], "_rd.rdata"}, rd_arr[p].rdata,
                dp[p].hrdata & lane_mask(exp_size[p], exp_ofs[p]));
      check_val({port_name[p], "_rd.hready"}, rd_arr[p].hready, dp[p].hready);
      check_val({port_name[p], "_rd.err"}, rd_arr[p].err, dp[p].hresp[0]);
    end
    // counter zero in reset and plus one per edge after
    if (!pg_reset_b) begin
      cnt_exp = '0;
    end else begin
      cnt_exp = cnt_prev + 1'b1;
    end
    check_val("sys_cnt", sys_cnt, cnt_exp);
    cnt_prev = cnt_exp;
    check_val("cpu_rst_b", cpu_rst_b, pg_reset_b & hartreset_n);
    check_val("sys_rst", sys_rst, ndmreset_n);
    check_val("cpu_nmi", cpu_nmi, nmi_wake_int_lower[0]);
    check_val("cpu_wakeup", cpu_wakeup, nmi_wake_int_lower[1]);
  endtask

  task automatic drive_idle(input int p);
    ap[p].htrans = subsys_pkg::HTRANS_IDLE;
    ap[p].hwrite = 1'b0;
    ap[p].hsize  = subsys_pkg::HSIZE_WORD;
    ap[p].haddr  = '0;
    dp[p].hrdata = lcg_next();
    dp[p].hready = 1'b1;
    dp[p].hresp  = 2'b00;
  endtask

  // accepted nonseq read with random upper address
  task automatic drive_read(input int p, input logic [2:0] size, input logic [1:0] ofs);
    logic [31:0] r;
    r = lcg_next();
    ap[p].htrans = subsys_pkg::HTRANS_NONSEQ;
    ap[p].hwrite = 1'b0;
    ap[p].hsize  = subsys_pkg::hsize_e'(size);
    ap[p].haddr  = {r[31:2], ofs};
    dp[p].hrdata = lcg_next();
    dp[p].hready = 1'b1;
    dp[p].hresp  = {1'b0, r[7]};
  endtask

  // phase that must not change the capture
  // kind 0 write, 1 seq, 2 idle, 3 busy, 4 nonseq read stalled
  task automatic drive_hold(input int p, input int kind);
    logic [31:0] r;
    r = lcg_next();
    ap[p].hwrite = (kind == 0);
    ap[p].hsize  = subsys_pkg::hsize_e'(r[18:16]);
    ap[p].haddr  = lcg_next();
    dp[p].hrdata = lcg_next();
    dp[p].hready = (kind != 4);
    dp[p].hresp  = r[21:20];
    case (kind)
      1: ap[p].htrans = subsys_pkg::HTRANS_SEQ;
      2: ap[p].htrans = subsys_pkg::HTRANS_IDLE;
      3: ap[p].htrans = subsys_pkg::HTRANS_BUSY;
      default: ap[p].htrans = subsys_pkg::HTRANS_NONSEQ;
    endcase
  endtask

  // any phase with sizes biased towards the legal ones
  task automatic drive_random(input int p);
    logic [31:0] r;
    r = lcg_next();
    ap[p].htrans = subsys_pkg::htrans_e'(r[17:16]);
    ap[p].hwrite = (r[20:18] == 3'd0);
    if (r[23:21] == 3'd7) begin
      ap[p].hsize = subsys_pkg::hsize_e'(r[26:24]);
    end else begin
      ap[p].hsize = subsys_pkg::hsize_e'(r[25:24] % 3);
    end
    ap[p].haddr  = lcg_next();
    dp[p].hrdata = lcg_next();
    dp[p].hready = (r[29:28] != 2'd0);
    dp[p].hresp  = r[31:30];
  endtask

  task automatic wait_core_out_of_reset();
    int n;
    n = 0;
    while (cpu_rst_b !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        stop_run("timeout: cpu_rst_b stayed low after pg_reset_b was released");
      end
      step_and_check();
      n++;
    end
  endtask

  initial begin
    logic [31:0] r;
    lcg_state          = 32'h6267;
    port_name[0]       = "sys";
    port_name[1]       = "ibus";
    port_name[2]       = "dbus";
    cpu_clk            = 1'b0;
    pg_reset_b         = 1'b0;
    hartreset_n        = 1'b1;
    ndmreset_n         = 1'b1;
    nmi_wake_int_lower = 2'b00;
    cnt_prev           = '0;
    for (int p = 0; p < NPORT; p++) begin
      drive_idle(p);
      exp_size[p] = 3'd2;
      exp_ofs[p]  = 2'd0;
    end

    // power-gated reset holds counter and core reset
    repeat (RST_CYCLES) begin
      step_and_check();
      for (int p = 0; p < NPORT; p++) begin
        drive_idle(p);
      end
    end
    pg_reset_b = 1'b1;
    wait_core_out_of_reset();

    // word passthrough straight after reset
    repeat (8) begin
      for (int p = 0; p < NPORT; p++) begin
        drive_idle(p);
      end
      step_and_check();
    end

    // every size and offset followed by two phases that must not capture
    for (int sz = 0; sz < 8; sz++) begin
      for (int ofs = 0; ofs < 4; ofs++) begin
        for (int p = 0; p < NPORT; p++) begin
          drive_read(p, sz[2:0], ofs[1:0]);
        end
        step_and_check();
        for (int p = 0; p < NPORT; p++) begin
          drive_hold(p, (sz * 4 + ofs + p) % 5);
        end
        step_and_check();
        for (int p = 0; p < NPORT; p++) begin
          drive_hold(p, (sz * 4 + ofs + p + 2) % 5);
        end
        step_and_check();
      end
    end

    // mixed traffic with reset requests and events toggling
    repeat (RAND_CYCLES) begin
      for (int p = 0; p < NPORT; p++) begin
        drive_random(p);
      end
      r = lcg_next();
      hartreset_n        = r[16];
      ndmreset_n         = r[17];
      nmi_wake_int_lower = r[19:18];
      step_and_check();
    end

    // short second power-gated reset restarts the counter from zero
    pg_reset_b = 1'b0;
    repeat (3) begin
      step_and_check();
    end
    pg_reset_b = 1'b1;
    repeat (20) begin
      for (int p = 0; p < NPORT; p++) begin
        drive_random(p);
      end
      step_and_check();
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- cpu_subsys_glue.sv
//--------------------------------------------------------------------------
// Glue logic that sits around the processor core.
// Three AHB-Lite read aligners (system, instruction, data) and the
// counter/reset/event block. The core and the slaves connect outside.
// All three ports share cpu_clk and pg_reset_b; no clock crossing here.
// Write data and all other bus signals do not pass through this block.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "subsys_defs.svh"

module cpu_subsys_glue (
  input  logic                         cpu_clk,
  input  logic                         pg_reset_b,
  input  logic                         hartreset_n,
  input  logic                         ndmreset_n,
  input  logic [1:0]                   nmi_wake_int_lower,

  // address phases from the core masters
  input  subsys_pkg::ahb_addr_phase_t  sys_addr_phase,
  input  subsys_pkg::ahb_addr_phase_t  ibus_addr_phase,
  input  subsys_pkg::ahb_addr_phase_t  dbus_addr_phase,

  // data phases from the slaves
  input  subsys_pkg::ahb_data_phase_t  sys_data_phase,
  input  subsys_pkg::ahb_data_phase_t  ibus_data_phase,
  input  subsys_pkg::ahb_data_phase_t  dbus_data_phase,

  // aligned responses back to the core
  output subsys_pkg::ahb_rd_aligned_t  sys_rd,
  output subsys_pkg::ahb_rd_aligned_t  ibus_rd,
  output subsys_pkg::ahb_rd_aligned_t  dbus_rd,

  // core control
  output logic                         cpu_rst_b,
  output logic                         sys_rst,
  output logic                         cpu_nmi,
  output logic                         cpu_wakeup,
  output logic [`SYS_CNT_W-1:0]        sys_cnt
);

  // system bus port
  ahbl_rdata_aligner u_sys_align (
    .cpu_clk    (cpu_clk),
    .pg_reset_b (pg_reset_b),
    .addr_phase (sys_addr_phase),
    .data_phase (sys_data_phase),
    .rd_aligned (sys_rd)
  );

  // instruction fetch port
  // fetches are mostly word, half for compressed code
  ahbl_rdata_aligner u_ibus_align (
    .cpu_clk    (cpu_clk),
    .pg_reset_b (pg_reset_b),
    .addr_phase (ibus_addr_phase),
    .data_phase (ibus_data_phase),
    .rd_aligned (ibus_rd)
  );

  // data port, all sizes
  ahbl_rdata_aligner u_dbus_align (
    .cpu_clk    (cpu_clk),
    .pg_reset_b (pg_reset_b),
    .addr_phase (dbus_addr_phase),
    .data_phase (dbus_data_phase),
    .rd_aligned (dbus_rd)
  );

  // counter, resets and events
  subsys_ctrl u_ctrl (
    .cpu_clk            (cpu_clk),
    .pg_reset_b         (pg_reset_b),
    .hartreset_n        (hartreset_n),
    .ndmreset_n         (ndmreset_n),
    .nmi_wake_int_lower (nmi_wake_int_lower),
    .cpu_rst_b          (cpu_rst_b),
    .sys_rst            (sys_rst),
    .cpu_nmi            (cpu_nmi),
    .cpu_wakeup         (cpu_wakeup),
    .sys_cnt            (sys_cnt)
  );

endmodule

//--- subsys_ctrl.sv
//--------------------------------------------------------------------------
// System counter, core reset combining and nmi/wakeup split.
// The counter runs from pg_reset_b only; a debug hart reset does not
// clear it. The reset and event outputs are pure combinational and
// need synchronising by the receiver if their sources are async.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "subsys_defs.svh"

module subsys_ctrl (
  input  logic                   cpu_clk,
  input  logic                   pg_reset_b,
  // debug module reset requests, active low
  input  logic                   hartreset_n,
  input  logic                   ndmreset_n,
  // bit 0 nmi, bit 1 wakeup
  input  logic [1:0]             nmi_wake_int_lower,
  output logic                   cpu_rst_b,
  output logic                   sys_rst,
  output logic                   cpu_nmi,
  output logic                   cpu_wakeup,
  output logic [`SYS_CNT_W-1:0]  sys_cnt
);

  // incremented counter value, wraps at full width
  logic [`SYS_CNT_W-1:0] sys_cnt_nxt;

  assign sys_cnt_nxt = sys_cnt + 1'b1;

  // free-running system counter
  // zero while power-gated reset is held
  always_ff @(posedge cpu_clk or negedge pg_reset_b) begin
    if (!pg_reset_b) begin
      sys_cnt <= '0;
    end else begin
      sys_cnt <= sys_cnt_nxt;
    end
  end

  // core held in reset by either source
  assign cpu_rst_b = pg_reset_b & hartreset_n;

  // non-debug-module reset goes out as is
  // active level is the debug module's
  assign sys_rst = ndmreset_n;

  // event split
  assign cpu_nmi    = nmi_wake_int_lower[0];
  assign cpu_wakeup = nmi_wake_int_lower[1];

endmodule

//--- ahbl_rdata_aligner.sv
//--------------------------------------------------------------------------
// Read-data lane alignment for one AHB-Lite master port.
// Observes the bus only, never stalls it. Size and offset are captured
// on accepted NONSEQ reads only; SEQ beats reuse the last capture, so
// bursts must keep the size and lane of their first beat.
// Unsupported size/offset pairs return all-zero read data.
// rdata is combinational from hrdata, no added latency.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "subsys_defs.svh"

module ahbl_rdata_aligner (
  input  logic                         cpu_clk,
  input  logic                         pg_reset_b,
  input  subsys_pkg::ahb_addr_phase_t  addr_phase,
  input  subsys_pkg::ahb_data_phase_t  data_phase,
  output subsys_pkg::ahb_rd_aligned_t  rd_aligned
);

  // byte lanes in one beat
  localparam int LANES = 1 << `LANE_OFS_W;

  // captured read size and byte offset
  subsys_pkg::hsize_e          cap_size;
  logic [`LANE_OFS_W-1:0]      cap_ofs;

  // phase accepted and starts a new read
  logic                        rd_start;

  // lanes that survive in the data phase
  logic [LANES-1:0]            lane_keep;
  logic [`HDATA_W-1:0]         rdata_algn;

  // accept on hready, only nonseq reads update
  assign rd_start = data_phase.hready
                    && (addr_phase.htrans == subsys_pkg::HTRANS_NONSEQ)
                    && !addr_phase.hwrite;

  // capture register
  // reset value is word at offset 0 -> passthrough
  always_ff @(posedge cpu_clk or negedge pg_reset_b) begin
    if (!pg_reset_b) begin
      cap_size <= subsys_pkg::HSIZE_WORD;
      cap_ofs  <= '0;
    end else if (rd_start) begin
      cap_size <= addr_phase.hsize;
      cap_ofs  <= addr_phase.haddr[`LANE_OFS_W-1:0];
    end
  end

  // lane select from size and offset
  always_comb begin
    lane_keep = '0;
    case (cap_size)
      subsys_pkg::HSIZE_BYTE: begin
        // any offset is legal for a byte
        lane_keep[cap_ofs] = 1'b1;
      end
      subsys_pkg::HSIZE_HALF: begin
        // halfword must sit at offset 0 or 2
        if (!cap_ofs[0]) begin
          lane_keep[cap_ofs +: 2] = 2'b11;
        end
      end
      subsys_pkg::HSIZE_WORD: begin
        // only aligned words pass
        if (cap_ofs == '0) begin
          lane_keep = '1;
        end
      end
      default: begin
        // wider sizes unsupported, all lanes zero
        lane_keep = '0;
      end
    endcase
  end

  // keep selected lanes in place, zero the rest
  always_comb begin
    rdata_algn = '0;
    for (int i = 0; i < LANES; i++) begin
      if (lane_keep[i]) begin
        rdata_algn[i*8 +: 8] = data_phase.hrdata[i*8 +: 8];
      end
    end
  end

  // back to the core
  always_comb begin
    rd_aligned.rdata  = rdata_algn;
    // handshake passes straight through
    rd_aligned.hready = data_phase.hready;
    // core only sees the error bit
    rd_aligned.err    = data_phase.hresp[0];
  end

endmodule

//--- subsys_pkg.sv
//--------------------------------------------------------------------------
// Shared AHB-Lite types for the core glue.
// Only byte, half and word sizes are supported. Larger hsize codes are
// legal encodings but the aligner returns zero data for them.
// hresp is kept two bits wide as the slaves drive it; only bit 0 is
// forwarded to the core as the error flag.
//--------------------------------------------------------------------------

`include "subsys_defs.svh"

package subsys_pkg;

  // AHB-Lite htrans encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // AHB-Lite hsize encoding, up to word only
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  // address phase, driven by the core side master
  typedef struct packed {
    htrans_e                htrans;
    logic                   hwrite;
    hsize_e                 hsize;
    logic [`HADDR_W-1:0]    haddr;
  } ahb_addr_phase_t;

  // data phase response from the slave
  typedef struct packed {
    logic [`HDATA_W-1:0]    hrdata;
    logic                   hready;
    // okay / error, bit 1 unused by the core
    logic [1:0]             hresp;
  } ahb_data_phase_t;

  // what the core gets back
  typedef struct packed {
    logic [`HDATA_W-1:0]    rdata;
    logic                   hready;
    logic                   err;
  } ahb_rd_aligned_t;

endpackage

//--- subsys_defs.svh
//--------------------------------------------------------------------------
// Bus and counter widths shared by the core glue.
// The AHB-Lite data width is fixed by the core at 32 bits. The lane
// steering in the aligner covers 4 byte lanes, so HDATA_W must stay
// equal to 8 << LANE_OFS_W.
// The system counter width must match the core's counter input.
//--------------------------------------------------------------------------

`ifndef SUBSYS_DEFS_SVH
`define SUBSYS_DEFS_SVH

// AHB-Lite address width, all three master ports
`define HADDR_W 32

// AHB-Lite read and write data width
`define HDATA_W 32

// byte offset inside one data beat
// (haddr low bits seen by the aligner)
`define LANE_OFS_W 2

// free-running system counter
`define SYS_CNT_W 64

`endif
